/* design/spu_pkg.sv */
package spu_pkg;

	localparam int data_width = 128;
	localparam int reg_count = 128;
	localparam int reg_addr_width = 7;

	// cycles from accept to register write
	localparam int even_latency = 2;
	localparam int odd_latency = 4;

	localparam logic [10:0] op_a = 11'b00011000000;
	localparam logic [10:0] op_and = 11'b00011000001;
	localparam logic [10:0] op_or = 11'b00001000001;
	localparam logic [10:0] op_xor = 11'b01001000001;
	localparam logic [10:0] op_shlqbyi = 11'b00111111111;
	localparam logic [10:0] op_nop = 11'b01000000001;
	localparam logic [7:0] op_ai = 8'b00011100;

	typedef struct packed {
		logic [10:0] op;
		logic [reg_addr_width-1:0] rb;
		logic [reg_addr_width-1:0] ra;
		logic [reg_addr_width-1:0] rt;
	} rr_t;

	typedef struct packed {
		logic [7:0] op;
		logic signed [9:0] imm;
		logic [reg_addr_width-1:0] ra;
		logic [reg_addr_width-1:0] rt;
	} ri10_t;

	// ra and rt sit in the same bits in both forms
	typedef union packed {
		rr_t rr;
		ri10_t ri10;
	} instr_u;

	typedef enum logic [2:0] {
		exec_nop,
		exec_add,
		exec_add_imm,
		exec_and,
		exec_or,
		exec_xor,
		exec_shift_bytes
	} exec_op_t;

	typedef struct packed {
		logic valid;
		exec_op_t op;
		logic [reg_addr_width-1:0] rt;
		logic [data_width-1:0] opnd_a;
		logic [data_width-1:0] opnd_b;
		logic signed [9:0] imm10;
	} issue_t;

	typedef struct packed {
		logic valid;
		logic [reg_addr_width-1:0] addr;
		logic [data_width-1:0] data;
	} wb_t;

endpackage

/* design/register_file.sv */
`timescale 1ns/1ps

module register_file import spu_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic [3:0][reg_addr_width-1:0] rd_addr,
	output logic [3:0][data_width-1:0] rd_data,
	input wb_t even_wb,
	input wb_t odd_wb
);

	logic [data_width-1:0] regs [reg_count];

	always_comb
	begin
		for (int i = 0; i < 4; i++)
			rd_data[i] = regs[rd_addr[i]];
	end

	// the scoreboard keeps the two write addresses apart
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < reg_count; i++)
				regs[i] <= '0;
		end
		else
		begin
			if (even_wb.valid)
				regs[even_wb.addr] <= even_wb.data;
			if (odd_wb.valid)
				regs[odd_wb.addr] <= odd_wb.data;
		end
	end

endmodule

/* design/even_fixed_pipe.sv */
`timescale 1ns/1ps

module even_fixed_pipe import spu_pkg::*;
(
	input logic clk,
	input logic reset,
	input issue_t issue,
	output wb_t wb
);

	logic [data_width-1:0] result;
	logic [31:0] imm_word;
	wb_t stage_q [even_latency];

	assign imm_word = {{22{issue.imm10[9]}}, issue.imm10};

	// word-wise, no carry across 32-bit lanes
	always_comb
	begin
		logic [31:0] a_w;
		logic [31:0] b_w;
		result = '0;
		for (int w = 0; w < data_width / 32; w++)
		begin
			a_w = issue.opnd_a[w*32 +: 32];
			b_w = issue.opnd_b[w*32 +: 32];
			case (issue.op)
				exec_add: result[w*32 +: 32] = a_w + b_w;
				exec_add_imm: result[w*32 +: 32] = a_w + imm_word;
				exec_and: result[w*32 +: 32] = a_w & b_w;
				exec_or: result[w*32 +: 32] = a_w | b_w;
				exec_xor: result[w*32 +: 32] = a_w ^ b_w;
				default: result[w*32 +: 32] = '0;
			endcase
		end
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < even_latency; i++)
				stage_q[i] <= '0;
		end
		else
		begin
			stage_q[0] <= '{valid: issue.valid && issue.op != exec_nop, addr: issue.rt,
				data: result};
			for (int i = 1; i < even_latency; i++)
				stage_q[i] <= stage_q[i-1];
		end
	end

	assign wb = stage_q[even_latency-1];

endmodule

/* design/odd_permute_pipe.sv */
`timescale 1ns/1ps

module odd_permute_pipe import spu_pkg::*;
(
	input logic clk,
	input logic reset,
	input issue_t issue,
	output wb_t wb
);

	logic [data_width-1:0] result;
	logic [7:0] shift_bits;
	logic take;
	wb_t stage_q [odd_latency];

	// byte count to bit count, 16 bytes or more clears the word
	assign shift_bits = {issue.imm10[4:0], 3'b000};
	assign take = issue.valid && issue.op == exec_shift_bytes;
	assign result = take ? (issue.opnd_a << shift_bits) : '0;

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < odd_latency; i++)
				stage_q[i] <= '0;
		end
		else
		begin
			stage_q[0] <= '{valid: take, addr: issue.rt, data: result};
			for (int i = 1; i < odd_latency; i++)
				stage_q[i] <= stage_q[i-1];
		end
	end

	assign wb = stage_q[odd_latency-1];

endmodule

/* design/issue_unit.sv */
`timescale 1ns/1ps

module issue_unit import spu_pkg::*;
(
	input logic clk,
	input logic reset,
	input instr_u instr_a,
	input instr_u instr_b,
	input logic pair_valid,
	input wb_t even_wb,
	input wb_t odd_wb,
	input logic [3:0][data_width-1:0] rd_data,
	output logic pair_stall,
	output logic [3:0][reg_addr_width-1:0] rd_addr,
	output issue_t even_issue,
	output issue_t odd_issue
);

	typedef struct packed {
		exec_op_t op;
		logic to_even;
		logic to_odd;
		logic uses_a;
		logic uses_b;
		logic writes;
		logic [reg_addr_width-1:0] rt;
		logic [reg_addr_width-1:0] ra;
		logic [reg_addr_width-1:0] rb;
		logic signed [9:0] imm10;
	} dec_t;

	dec_t dec_a;
	dec_t dec_b;
	logic [reg_count-1:0] pending;
	logic first_done;
	logic busy_a;
	logic busy_b;
	logic same_pipe;
	logic depends;
	logic go_a;
	logic go_b;

	// unknown words fall through as nop
	function automatic dec_t decode(input instr_u w);
		dec_t d;
		d = '0;
		d.op = exec_nop;
		d.rt = w.rr.rt;
		d.ra = w.rr.ra;
		d.rb = w.rr.rb;
		if (w.ri10.op == op_ai)
		begin
			d.op = exec_add_imm;
			d.imm10 = w.ri10.imm;
			d.to_even = 1'b1;
			d.uses_a = 1'b1;
			d.writes = 1'b1;
		end
		else
		begin
			case (w.rr.op)
				op_a, op_and, op_or, op_xor:
				begin
					d.op = (w.rr.op == op_a) ? exec_add :
						(w.rr.op == op_and) ? exec_and :
						(w.rr.op == op_or) ? exec_or : exec_xor;
					d.to_even = 1'b1;
					d.uses_a = 1'b1;
					d.uses_b = 1'b1;
					d.writes = 1'b1;
				end
				op_shlqbyi:
				begin
					// byte count is the low nibble of the rb field
					d.op = exec_shift_bytes;
					d.imm10 = {6'b0, w.rr.rb[3:0]};
					d.to_odd = 1'b1;
					d.uses_a = 1'b1;
					d.writes = 1'b1;
				end
				op_nop: d.op = exec_nop;
				default: d.op = exec_nop;
			endcase
		end
		return d;
	endfunction

	function automatic logic is_busy(input dec_t d, input logic [reg_count-1:0] pend);
		return (d.uses_a && pend[d.ra]) || (d.uses_b && pend[d.rb]) ||
			(d.writes && pend[d.rt]);
	endfunction

	function automatic issue_t make_issue(input dec_t d, input logic [data_width-1:0] a,
		input logic [data_width-1:0] b);
		issue_t s;
		s.valid = 1'b1;
		s.op = d.op;
		s.rt = d.rt;
		s.opnd_a = a;
		s.opnd_b = b;
		s.imm10 = d.imm10;
		return s;
	endfunction

	assign dec_a = decode(instr_a);
	assign dec_b = decode(instr_b);

	assign rd_addr[0] = dec_a.ra;
	assign rd_addr[1] = dec_a.rb;
	assign rd_addr[2] = dec_b.ra;
	assign rd_addr[3] = dec_b.rb;

	assign busy_a = is_busy(dec_a, pending);
	assign busy_b = is_busy(dec_b, pending);

	// pair has to split
	assign same_pipe = (dec_a.to_even && dec_b.to_even) || (dec_a.to_odd && dec_b.to_odd);
	assign depends = dec_a.writes && ((dec_b.uses_a && dec_b.ra == dec_a.rt) ||
		(dec_b.uses_b && dec_b.rb == dec_a.rt) || (dec_b.writes && dec_b.rt == dec_a.rt));

	// younger word never passes the older one
	assign go_a = pair_valid && !first_done && !busy_a;
	assign go_b = pair_valid && !busy_b && (first_done || (go_a && !same_pipe && !depends));
	assign pair_stall = pair_valid && !go_b;

	always_comb
	begin
		even_issue = '0;
		odd_issue = '0;
		if (go_a && dec_a.to_even)
			even_issue = make_issue(dec_a, rd_data[0], rd_data[1]);
		else if (go_b && dec_b.to_even)
			even_issue = make_issue(dec_b, rd_data[2], rd_data[3]);
		if (go_a && dec_a.to_odd)
			odd_issue = make_issue(dec_a, rd_data[0], rd_data[1]);
		else if (go_b && dec_b.to_odd)
			odd_issue = make_issue(dec_b, rd_data[2], rd_data[3]);
	end

	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			first_done <= 1'b0;
		end
		else if (go_b)
		begin
			first_done <= 1'b0;
		end
		else if (go_a)
		begin
			first_done <= 1'b1;
		end
	end

	// scoreboard, clear on writeback and set on dispatch
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			pending <= '0;
		end
		else
		begin
			if (even_wb.valid)
				pending[even_wb.addr] <= 1'b0;
			if (odd_wb.valid)
				pending[odd_wb.addr] <= 1'b0;
			if (even_issue.valid)
				pending[even_issue.rt] <= 1'b1;
			if (odd_issue.valid)
				pending[odd_issue.rt] <= 1'b1;
		end
	end

endmodule

/* design/spu_core.sv */
`timescale 1ns/1ps

module spu_core import spu_pkg::*;
(
	input logic clk,
	input logic reset,
	input instr_u instr_a,
	input instr_u instr_b,
	input logic pair_valid,
	output logic pair_stall,
	output wb_t even_wb,
	output wb_t odd_wb
);

	issue_t even_issue;
	issue_t odd_issue;
	logic [3:0][reg_addr_width-1:0] rd_addr;
	logic [3:0][data_width-1:0] rd_data;

	issue_unit u_issue
	(
		.clk(clk),
		.reset(reset),
		.instr_a(instr_a),
		.instr_b(instr_b),
		.pair_valid(pair_valid),
		.even_wb(even_wb),
		.odd_wb(odd_wb),
		.rd_data(rd_data),
		.pair_stall(pair_stall),
		.rd_addr(rd_addr),
		.even_issue(even_issue),
		.odd_issue(odd_issue)
	);

	even_fixed_pipe u_even
	(
		.clk(clk),
		.reset(reset),
		.issue(even_issue),
		.wb(even_wb)
	);

	odd_permute_pipe u_odd
	(
		.clk(clk),
		.reset(reset),
		.issue(odd_issue),
		.wb(odd_wb)
	);

	// written at the end of each wb cycle
	register_file u_rf
	(
		.clk(clk),
		.reset(reset),
		.rd_addr(rd_addr),
		.rd_data(rd_data),
		.even_wb(even_wb),
		.odd_wb(odd_wb)
	);

endmodule

/* tb/clock_gen.sv */
`timescale 1ns/1ps

module clock_gen
(
	output logic clk,
	output logic reset
);

	// 40 ns period
	initial
	begin
		clk = 1'b0;
		forever
			#20 clk = ~clk;
	end

	initial
	begin
		reset = 1'b1;
		repeat (4) @(posedge clk);
		#1;
		reset = 1'b0;
	end

endmodule

/* tb/spu_core_asserts.sv */
`timescale 1ns/1ps

module spu_core_asserts import spu_pkg::*;
(
	input logic clk,
	input logic reset,
	input logic pair_valid,
	input logic pair_stall,
	input logic [reg_count-1:0] pending,
	input issue_t even_issue,
	input issue_t odd_issue
);

	int fail_count = 0;

	stall_needs_pair: assert property (@(posedge clk) disable iff (reset)
		pair_stall |-> pair_valid)
	else
	begin
		$error("pair_stall is high with no pair present");
		fail_count++;
	end

	even_target_free: assert property (@(posedge clk) disable iff (reset)
		even_issue.valid |-> !pending[even_issue.rt])
	else
	begin
		$error("even dispatch to a register with a write in flight");
		fail_count++;
	end

	odd_target_free: assert property (@(posedge clk) disable iff (reset)
		odd_issue.valid |-> !pending[odd_issue.rt])
	else
	begin
		$error("odd dispatch to a register with a write in flight");
		fail_count++;
	end

	// first edge out of reset
	no_stall_after_reset: assert property (@(posedge clk) reset |=> !pair_stall)
	else
	begin
		$error("pair_stall is high right after reset");
		fail_count++;
	end

endmodule

bind issue_unit spu_core_asserts u_asserts
(
	.clk(clk),
	.reset(reset),
	.pair_valid(pair_valid),
	.pair_stall(pair_stall),
	.pending(pending),
	.even_issue(even_issue),
	.odd_issue(odd_issue)
);

/* tb/spu_core_tb.sv */
`timescale 1ns/1ps

module spu_core_tb import spu_pkg::*;
();

	logic clk;
	logic reset;
	instr_u instr_a;
	instr_u instr_b;
	logic pair_valid;
	logic pair_stall;
	wb_t even_wb;
	wb_t odd_wb;

	// expected writebacks, index 0 even and 1 odd
	logic [data_width-1:0] model_regs [reg_count];
	wb_t exp_q [2][$];
	logic [31:0] rng_state;
	instr_u nop;
	string test_name;

	clock_gen u_clock (.*);
	spu_core uut (.*);

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Test failed");
		$fatal(1);
	endtask

	task automatic check(input string what, input logic [data_width-1:0] expected,
		input logic [data_width-1:0] actual);
		if (expected !== actual)
			stop_run($sformatf("FAIL %s %s expected %h actual %h", test_name, what,
				expected, actual));
	endtask

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s ^ (s << 13);
		x = x ^ (x >> 17);
		return x ^ (x << 5);
	endfunction

	function automatic instr_u rr_word(input logic [10:0] op, input int rb, input int ra,
		input int rt);
		return {op, 7'(rb), 7'(ra), 7'(rt)};
	endfunction

	function automatic instr_u ai_word(input int imm, input int ra, input int rt);
		return {op_ai, 10'(imm), 7'(ra), 7'(rt)};
	endfunction

	// program-order effect of one word and the writeback it owes
	task automatic model_word(input instr_u w);
		logic [data_width-1:0] a;
		logic [data_width-1:0] r;
		logic [31:0] y;
		logic is_ai;
		int p;
		a = model_regs[w.rr.ra];
		r = '0;
		is_ai = w.ri10.op == op_ai;
		p = -1;
		if (is_ai || w.rr.op inside {op_a, op_and, op_or, op_xor})
		begin
			p = 0;
			for (int l = 0; l < 4; l++)
			begin
				y = is_ai ? {{22{w.ri10.imm[9]}}, w.ri10.imm} : model_regs[w.rr.rb][l*32 +: 32];
				case (is_ai ? op_a : w.rr.op)
					op_and: r[l*32 +: 32] = a[l*32 +: 32] & y;
					op_or: r[l*32 +: 32] = a[l*32 +: 32] | y;
					op_xor: r[l*32 +: 32] = a[l*32 +: 32] ^ y;
					default: r[l*32 +: 32] = a[l*32 +: 32] + y;
				endcase
			end
		end
		else if (w.rr.op == op_shlqbyi)
		begin
			p = 1;
			r = a << (8 * w.rr.rb[3:0]);
		end
		if (p >= 0)
		begin
			model_regs[w.rr.rt] = r;
			exp_q[p].push_back(wb_t'{1'b1, w.rr.rt, r});
		end
	endtask

	// the pair is taken at the first edge with pair_stall low
	task automatic send_pair(input instr_u a, input instr_u b);
		instr_a = a;
		instr_b = b;
		pair_valid = 1'b1;
		model_word(a);
		model_word(b);
		@(negedge clk);
		while (pair_stall)
			@(negedge clk);
		@(posedge clk);
		#1;
		pair_valid = 1'b0;
	endtask

	task automatic drain();
		while (exp_q[0].size() + exp_q[1].size() != 0)
			@(posedge clk);
		@(posedge clk);
		#1;
	endtask

	task automatic retire(input int p, input wb_t got);
		wb_t exp;
		if (exp_q[p].size() == 0)
			stop_run($sformatf("%s pipe wrote r%0d with nothing in flight",
				p ? "odd" : "even", got.addr));
		exp = exp_q[p].pop_front();
		check(p ? "odd_wb addr" : "even_wb addr", data_width'(exp.addr), data_width'(got.addr));
		check(p ? "odd_wb data" : "even_wb data", exp.data, got.data);
	endtask

	always @(negedge clk)
	begin
		if (uut.u_issue.u_asserts.fail_count != 0)
			stop_run("an assertion on the issue unit failed");
		if (even_wb.valid)
			retire(0, even_wb);
		if (odd_wb.valid)
			retire(1, odd_wb);
	end

	function automatic instr_u random_word();
		logic [31:0] s;
		int rt;
		int ra;
		int rb;
		rng_state = xorshift(rng_state);
		s = rng_state;
		rt = int'(s[4:0]);
		ra = int'(s[9:5]);
		rb = int'(s[14:10]);
		case (s[17:15])
			3'd0: return nop;
			3'd1: return rr_word(op_a, rb, ra, rt);
			3'd2: return rr_word(op_and, rb, ra, rt);
			3'd3: return rr_word(op_or, rb, ra, rt);
			3'd4: return rr_word(op_xor, rb, ra, rt);
			3'd5: return ai_word(int'(s[27:18]), ra, rt);
			default: return rr_word(op_shlqbyi, rb, ra, rt);
		endcase
	endfunction

	task automatic test_reset();
		test_name = "reset";
		check("even_wb valid", '0, data_width'(even_wb.valid));
		check("odd_wb valid", '0, data_width'(odd_wb.valid));
		check("pair_stall", '0, data_width'(pair_stall));
		send_pair(rr_word(op_a, 2, 1, 3), nop);
		drain();
	endtask

	task automatic test_even();
		test_name = "even ops";
		send_pair(ai_word(100, 0, 1), ai_word(-3, 0, 2));
		send_pair(ai_word(-1, 0, 4), ai_word(300, 0, 5));
		// all-ones lanes plus 100 wrap to 99
		send_pair(rr_word(op_a, 1, 4, 6), rr_word(op_and, 2, 1, 7));
		send_pair(rr_word(op_or, 2, 1, 8), rr_word(op_xor, 4, 5, 9));
		drain();
	endtask

	task automatic test_odd();
		test_name = "odd shift";
		// lanes that differ from each other
		send_pair(ai_word(301, 0, 10), rr_word(op_shlqbyi, 5, 10, 11));
		send_pair(rr_word(op_xor, 11, 2, 12), nop);
		send_pair(rr_word(op_shlqbyi, 0, 12, 13), rr_word(op_shlqbyi, 5, 12, 14));
		send_pair(nop, rr_word(op_shlqbyi, 15, 12, 15));
		drain();
	endtask

	task automatic test_split();
		test_name = "split pairs";
		send_pair(ai_word(7, 1, 20), ai_word(9, 1, 21));
		send_pair(ai_word(11, 0, 22), rr_word(op_a, 22, 22, 23));
		drain();
	endtask

	task automatic test_hazard();
		test_name = "hazards";
		send_pair(rr_word(op_shlqbyi, 3, 12, 30), nop);
		send_pair(rr_word(op_a, 1, 30, 31), nop);
		send_pair(ai_word(5, 1, 32), nop);
		send_pair(rr_word(op_shlqbyi, 2, 12, 32), nop);
		send_pair(ai_word(0, 32, 33), nop);
		drain();
	endtask

	task automatic test_random(input int n);
		instr_u a;
		instr_u b;
		test_name = "random";
		for (int i = 0; i < n; i++)
		begin
			a = random_word();
			b = random_word();
			send_pair(a, b);
		end
		drain();
		// each register copied onto itself shows its value on a writeback
		test_name = "readout";
		for (int i = 0; i < reg_count; i += 2)
			send_pair(ai_word(0, i, i), rr_word(op_shlqbyi, 0, i + 1, i + 1));
		drain();
	endtask

	initial
	begin
		nop = rr_word(op_nop, 0, 0, 0);
		instr_a = nop;
		instr_b = nop;
		pair_valid = 1'b0;
		rng_state = 32'd77;
		test_name = "startup";
		for (int i = 0; i < reg_count; i++)
			model_regs[i] = '0;
		@(negedge reset);
		@(posedge clk);
		#1;
		test_reset();
		test_even();
		test_odd();
		test_split();
		test_hazard();
		test_random(200);
		if (uut.u_issue.u_asserts.fail_count == 0)
		begin
			$display("Test passed");
			$finish;
		end
		else
			stop_run("an assertion on the issue unit failed during the run");
	end

	// worst case a pair splits and each word waits out an odd latency
	initial
	begin
		int pair_budget;
		pair_budget = 20 + 200 + reg_count / 2;
		#(pair_budget * 2 * (odd_latency + 2) * 40 + 4000);
		stop_run("watchdog expired before the tests finished");
	end

endmodule

/* list.f */
design/spu_pkg.sv
design/register_file.sv
design/even_fixed_pipe.sv
design/odd_permute_pipe.sv
design/issue_unit.sv
design/spu_core.sv
tb/clock_gen.sv
tb/spu_core_asserts.sv
tb/spu_core_tb.sv

/* run.sh */
#!/bin/sh
set -e
verilator --binary --timing --assert --top-module spu_core_tb -f list.f
./obj_dir/Vspu_core_tb | tee sim.log
grep -qx "Test passed" sim.log
